// ==== ahb_mem_settings.svh ====
// AHB memory subordinate settings
`ifndef AHB_MEM_SETTINGS_SVH
`define AHB_MEM_SETTINGS_SVH

// bus widths
`define AHB_DATA_WIDTH 32
`define AHB_ADDR_WIDTH 32

// storage geometry, 256 words = 1 KB
`define MEM_WORDS      256
`define MEM_INDEX_BITS 8    // log2 of MEM_WORDS

`endif

// ==== ahb_pkg.sv ====
// AHB protocol types
`default_nettype none

`include "ahb_mem_settings.svh"

package ahb_pkg;

  typedef logic [`AHB_ADDR_WIDTH-1:0] haddr_t;
  typedef logic [`AHB_DATA_WIDTH-1:0] hdata_t;

  // transfer type codes as on HTRANS
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  typedef logic [2:0] hsize_t;

  localparam hsize_t SIZE_BYTE = 3'b000;
  localparam hsize_t SIZE_HALF = 3'b001;
  localparam hsize_t SIZE_WORD = 3'b010;  // widest legal size

  localparam logic RESP_OKAY  = 1'b0;
  localparam logic RESP_ERROR = 1'b1;

  // data-phase response sequencing
  typedef enum logic [1:0] {OKAY, ERR_FIRST, ERR_SECOND} resp_state_t;

endpackage

`default_nettype wire

// ==== mem_pkg.sv ====
// word storage types
`default_nettype none

`include "ahb_mem_settings.svh"

package mem_pkg;

  typedef logic [`AHB_DATA_WIDTH-1:0]   word_t;
  typedef logic [`MEM_INDEX_BITS-1:0]   word_index_t;

  // one enable per byte lane, bit 0 is the low byte
  typedef logic [`AHB_DATA_WIDTH/8-1:0] byte_strb_t;

endpackage

`default_nettype wire

// ==== access_if.sv ====
// decoded access interface
`timescale 1ns/100ps
`default_nettype none

`include "ahb_mem_settings.svh"

interface access_if;

  logic                 pending;  // data phase is occupied
  logic                 write;
  mem_pkg::word_index_t index;
  mem_pkg::byte_strb_t  strb;
  logic                 error;    // illegal access, answer with ERROR

  modport prod (output pending, output write, output index, output strb, output error);

  modport cons (input pending, input write, input index, input strb, input error);

endinterface

`default_nettype wire

// ==== mem_if.sv ====
// storage port interface
`timescale 1ns/100ps
`default_nettype none

`include "ahb_mem_settings.svh"

interface mem_if;

  logic                 wen;
  mem_pkg::word_index_t index;
  mem_pkg::byte_strb_t  strb;
  mem_pkg::word_t       wdata;
  mem_pkg::word_t       rdata;  // async read of index

  modport owner (output wen, output index, output strb, output wdata, input rdata);

  modport store (input wen, input index, input strb, input wdata, output rdata);

endinterface

`default_nettype wire

// ==== ahb_addr_phase.sv ====
// AHB address phase decoder
`timescale 1ns/100ps
`default_nettype none

`include "ahb_mem_settings.svh"

module ahb_addr_phase (
  input  wire logic             HCLK,
  input  wire logic             HRESETn,
  input  wire logic             hsel,
  input  wire ahb_pkg::haddr_t  haddr,
  input  wire ahb_pkg::htrans_t htrans,
  input  wire logic             hwrite,
  input  wire ahb_pkg::hsize_t  hsize,
  input  wire logic             hready,
  access_if.prod                acc
);

  logic                sample;
  logic                out_of_range;
  logic                bad_size;
  logic                misaligned;
  mem_pkg::byte_strb_t strb_d;

  // ----------------------------------------------------------------------
  // qualify and check the address phase
  // ----------------------------------------------------------------------
  assign sample = hsel && hready &&
                  (htrans == ahb_pkg::NONSEQ || htrans == ahb_pkg::SEQ);

  assign out_of_range = |haddr[`AHB_ADDR_WIDTH-1:`MEM_INDEX_BITS+2];  // >= 1 KB
  assign bad_size     = hsize > ahb_pkg::SIZE_WORD;

  // lane enables, little endian
  always_comb begin
    misaligned = 1'b0;
    strb_d     = '0;
    case (hsize)
      ahb_pkg::SIZE_BYTE: strb_d = mem_pkg::byte_strb_t'(1) << haddr[1:0];
      ahb_pkg::SIZE_HALF: begin
        misaligned = haddr[0];
        strb_d     = mem_pkg::byte_strb_t'(3) << {haddr[1], 1'b0};
      end
      ahb_pkg::SIZE_WORD: begin
        misaligned = |haddr[1:0];
        strb_d     = '1;
      end
      default: strb_d = '0;  // oversize, flagged by bad_size
    endcase
  end

  // ----------------------------------------------------------------------
  // hand over to the data phase
  // ----------------------------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      acc.pending <= 1'b0;
      acc.error   <= 1'b0;
    end else begin
      acc.pending <= sample;  // idle, busy, deselect or stall retire it
      acc.error   <= sample && (out_of_range || bad_size || misaligned);
    end
  end

  always_ff @(posedge HCLK) begin
    if (sample) begin
      acc.write <= hwrite;
      acc.index <= haddr[`MEM_INDEX_BITS+1:2];
      acc.strb  <= strb_d;
    end
  end

endmodule

`default_nettype wire

// ==== word_storage.sv ====
// byte-writable word storage
`timescale 1ns/100ps
`default_nettype none

`include "ahb_mem_settings.svh"

module word_storage (
  input  wire logic HCLK,
  mem_if.store      mem
);

  mem_pkg::word_t mem_array [`MEM_WORDS];

  // one write port, lanes enabled by strb
  always_ff @(posedge HCLK) begin
    if (mem.wen) begin
      for (int b = 0; b < $bits(mem_pkg::byte_strb_t); b++) begin
        if (mem.strb[b]) begin
          mem_array[mem.index][8*b +: 8] <= mem.wdata[8*b +: 8];
        end
      end
    end
  end

  assign mem.rdata = mem_array[mem.index];  // zero-cycle read

endmodule

`default_nettype wire

// ==== ahb_data_phase.sv ====
// AHB data phase responder
`timescale 1ns/100ps
`default_nettype none

`include "ahb_mem_settings.svh"

module ahb_data_phase (
  input  wire logic            HCLK,
  input  wire logic            HRESETn,
  input  wire logic            hready,
  input  wire ahb_pkg::hdata_t hwdata,
  access_if.cons               acc,
  mem_if.owner                 mem,
  output ahb_pkg::hdata_t      hrdata,
  output logic                 hresp,
  output logic                 hreadyout
);

  ahb_pkg::resp_state_t state_q;
  ahb_pkg::resp_state_t state_cur;
  ahb_pkg::resp_state_t state_nxt;
  logic                 legal;

  // ----------------------------------------------------------------------
  // response FSM
  // ----------------------------------------------------------------------

  // an errored access starts its first cycle straight away,
  // so ERR_FIRST is seen combinationally and never registered
  always_comb begin
    state_cur = state_q;
    if (state_q == ahb_pkg::OKAY && acc.pending && acc.error) begin
      state_cur = ahb_pkg::ERR_FIRST;
    end
  end

  always_comb begin
    case (state_cur)
      ahb_pkg::ERR_FIRST: state_nxt = ahb_pkg::ERR_SECOND;
      default:            state_nxt = ahb_pkg::OKAY;  // second cycle ends it
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state_q <= ahb_pkg::OKAY;
    end else begin
      state_q <= state_nxt;
    end
  end

  assign hreadyout = (state_cur != ahb_pkg::ERR_FIRST);  // own stall
  assign hresp     = (state_cur == ahb_pkg::OKAY) ? ahb_pkg::RESP_OKAY
                                                  : ahb_pkg::RESP_ERROR;

  // ----------------------------------------------------------------------
  // storage access
  // ----------------------------------------------------------------------
  assign legal = acc.pending && !acc.error;

  assign mem.wen   = legal && acc.write && hready;  // commits at closing edge
  assign mem.index = acc.index;
  assign mem.strb  = acc.strb;
  assign mem.wdata = hwdata;

  // full word back, manager picks its lanes
  assign hrdata = (legal && !acc.write) ? mem.rdata : '0;

endmodule

`default_nettype wire

// ==== ahb_mem_sub.sv ====
// AHB memory subordinate top level
`timescale 1ns/100ps
`default_nettype none

`include "ahb_mem_settings.svh"

module ahb_mem_sub (
  input  wire logic             HCLK,
  input  wire logic             HRESETn,
  input  wire logic             hsel,
  input  wire ahb_pkg::haddr_t  haddr,
  input  wire ahb_pkg::htrans_t htrans,
  input  wire logic             hwrite,
  input  wire ahb_pkg::hsize_t  hsize,
  input  wire ahb_pkg::hdata_t  hwdata,
  input  wire logic             hready,     // bus-wide ready in
  output ahb_pkg::hdata_t       hrdata,
  output logic                  hresp,
  output logic                  hreadyout
);

  access_if acc_bus ();
  mem_if    mem_bus ();

  ahb_addr_phase u_addr (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .hsel    (hsel),
    .haddr   (haddr),
    .htrans  (htrans),
    .hwrite  (hwrite),
    .hsize   (hsize),
    .hready  (hready),
    .acc     (acc_bus.prod)
  );

  word_storage u_store (
    .HCLK (HCLK),
    .mem  (mem_bus.store)
  );

  ahb_data_phase u_data (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .hready    (hready),
    .hwdata    (hwdata),
    .acc       (acc_bus.cons),
    .mem       (mem_bus.owner),
    .hrdata    (hrdata),
    .hresp     (hresp),
    .hreadyout (hreadyout)
  );

endmodule

`default_nettype wire

// ==== ahb_checker.sv ====
// AHB transfer checker
`timescale 1ns/100ps
`default_nettype none

`include "ahb_mem_settings.svh"

module ahb_checker (
  input wire logic             HCLK,
  input wire logic             HRESETn,
  input wire logic             hsel,
  input wire ahb_pkg::haddr_t  haddr,
  input wire ahb_pkg::htrans_t htrans,
  input wire logic             hwrite,
  input wire ahb_pkg::hsize_t  hsize,
  input wire ahb_pkg::hdata_t  hwdata,
  input wire logic             hready,
  input wire ahb_pkg::hdata_t  hrdata,
  input wire logic             hresp,
  input wire logic             hreadyout
);

  localparam int MEM_BYTES = `MEM_WORDS * 4;

  logic [7:0] ref_mem [MEM_BYTES];  // reference bytes
  bit         known   [MEM_BYTES];

  int checks = 0;
  int errors = 0;

  // access currently in its data phase
  logic                 d_valid;
  logic                 d_write;
  ahb_pkg::haddr_t      d_addr;
  logic [3:0]           d_lanes;
  ahb_pkg::resp_state_t d_state;

  function automatic bit illegal(input ahb_pkg::haddr_t a, input ahb_pkg::hsize_t s);
    return (a >= MEM_BYTES) || (s > 3'd2) || (s == 3'd1 && a[0]) ||
           (s == 3'd2 && a[1:0] != 2'b00);
  endfunction

  function automatic logic [3:0] lanes_of(input ahb_pkg::haddr_t a, input ahb_pkg::hsize_t s);
    case (s)
      3'd0:    return 4'b0001 << a[1:0];
      3'd1:    return a[1] ? 4'b1100 : 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    if (exp !== got) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, got %h (addr %h)", name, exp, got, d_addr);
    end
  endtask

  // ----------------------------------------------------------------------
  // data phase compare, then address phase sampling
  // ----------------------------------------------------------------------
  always @(posedge HCLK or negedge HRESETn) begin
    logic [31:0] exp_word;
    logic [31:0] mask;
    int          base;
    if (!HRESETn) begin
      d_valid = 1'b0;
      d_state = ahb_pkg::OKAY;
    end else begin
      check_value($sformatf("hreadyout in %s", d_state.name()),
                  32'(d_state != ahb_pkg::ERR_FIRST), 32'(hreadyout));
      check_value($sformatf("hresp in %s", d_state.name()),
                  32'(d_state != ahb_pkg::OKAY), 32'(hresp));
      if (d_valid && d_state == ahb_pkg::OKAY && hready) begin
        base     = int'(d_addr[`MEM_INDEX_BITS+1:2]) * 4;
        exp_word = '0;
        mask     = '0;
        for (int b = 0; b < 4; b++) begin
          if (d_write && d_lanes[b]) begin
            ref_mem[base + b] = hwdata[8*b +: 8];
            known[base + b]   = 1'b1;
          end else if (!d_write && known[base + b]) begin
            exp_word[8*b +: 8] = ref_mem[base + b];
            mask[8*b +: 8]     = 8'hff;  // unknown bytes not compared
          end
        end
        if (!d_write) begin
          check_value("hrdata", exp_word, hrdata & mask);
        end
      end
      if (d_valid && d_state == ahb_pkg::ERR_FIRST) begin
        d_state = ahb_pkg::ERR_SECOND;
      end else if (hready) begin
        d_valid = 1'b0;
        d_state = ahb_pkg::OKAY;
      end
      if (hsel && hready && (htrans == ahb_pkg::NONSEQ || htrans == ahb_pkg::SEQ)) begin
        d_valid = 1'b1;
        d_write = hwrite;
        d_addr  = haddr;
        d_lanes = lanes_of(haddr, hsize);
        d_state = illegal(haddr, hsize) ? ahb_pkg::ERR_FIRST : ahb_pkg::OKAY;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_ahb_mem_sub.sv ====
// AHB memory subordinate testbench
`timescale 1ns/100ps
`default_nettype none

`include "ahb_mem_settings.svh"

module tb_ahb_mem_sub;

  localparam int TIMEOUT = 16;  // cycles allowed per wait
  localparam int N_XFER  = 16;

  logic             HCLK;
  logic             HRESETn;
  logic             hsel;
  ahb_pkg::haddr_t  haddr;
  ahb_pkg::htrans_t htrans;
  logic             hwrite;
  ahb_pkg::hsize_t  hsize;
  ahb_pkg::hdata_t  hwdata;
  logic             hready;
  logic             stall;      // another subordinate holds the bus
  ahb_pkg::hdata_t  hrdata;
  logic             hresp;
  logic             hreadyout;
  int               timeouts;
  int               timeout_mark;
  int               err_mark;
  ahb_pkg::haddr_t  used[$];    // word addresses written so far

  assign hready = hreadyout && !stall;  // single subordinate bus

  ahb_mem_sub uut (.*);

  ahb_checker chk (.*);

  initial begin
    HCLK = 1'b0;
    forever #10 HCLK = ~HCLK;
  end

  // ----------------------------------------------------------------------
  // bus helpers
  // ----------------------------------------------------------------------
  function automatic ahb_pkg::htrans_t active();
    return ($urandom_range(1) == 0) ? ahb_pkg::NONSEQ : ahb_pkg::SEQ;
  endfunction

  function automatic ahb_pkg::haddr_t pick_word();
    return used[$urandom_range(used.size() - 1)];
  endfunction

  task automatic note_timeout(input string what);
    $display("timeout: %s stayed low for %0d cycles", what, TIMEOUT);
    timeouts++;
  endtask

  task automatic drive_addr(input logic sel, input ahb_pkg::htrans_t trans,
                            input logic write, input ahb_pkg::haddr_t addr,
                            input ahb_pkg::hsize_t size);
    hsel   = sel;
    htrans = trans;
    hwrite = write;
    haddr  = addr;
    hsize  = size;
  endtask

  // address phase followed by a data phase on an idle bus
  task automatic transfer(input logic sel, input ahb_pkg::htrans_t trans,
                          input logic write, input ahb_pkg::haddr_t addr,
                          input ahb_pkg::hsize_t size);
    int n;
    drive_addr(sel, trans, write, addr, size);
    n = 0;
    while (!hready && n < TIMEOUT) begin
      @(negedge HCLK);
      n++;
    end
    if (!hready) begin
      note_timeout("hready");
    end
    @(negedge HCLK);
    drive_addr(1'b0, ahb_pkg::IDLE, 1'b0, '0, ahb_pkg::SIZE_WORD);
    hwdata = $urandom();
    n = 0;
    while (!hreadyout && n < TIMEOUT) begin
      @(negedge HCLK);
      n++;
    end
    if (!hreadyout) begin
      note_timeout("hreadyout");
    end
    @(negedge HCLK);  // past the closing edge
  endtask

  task automatic read_word(input ahb_pkg::haddr_t addr);
    transfer(1'b1, active(), 1'b0, addr, ahb_pkg::SIZE_WORD);
  endtask

  task automatic end_test(input string name);
    if (chk.errors == err_mark && timeouts == timeout_mark) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: FAILED", name);
    end
    err_mark     = chk.errors;
    timeout_mark = timeouts;
  endtask

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial begin
    ahb_pkg::haddr_t addr;
    void'($urandom(57));
    HRESETn      = 1'b0;
    stall        = 1'b0;
    hwdata       = '0;
    timeouts     = 0;
    timeout_mark = 0;
    err_mark     = 0;
    drive_addr(1'b0, ahb_pkg::IDLE, 1'b0, '0, ahb_pkg::SIZE_WORD);
    repeat (8) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;

    repeat (4) @(negedge HCLK);  // checker watches the idle bus response
    end_test("1 reset state");

    for (int i = 0; i < N_XFER; i++) begin
      addr = $urandom_range(`MEM_WORDS - 1) * 4;
      used.push_back(addr);
      transfer(1'b1, active(), 1'b1, addr, ahb_pkg::SIZE_WORD);
    end
    foreach (used[i]) read_word(used[i]);
    end_test("2 word write and read");

    for (int i = 0; i < 2 * N_XFER; i++) begin
      if ($urandom_range(1) == 0) begin
        transfer(1'b1, active(), 1'b1, pick_word() + $urandom_range(3), ahb_pkg::SIZE_BYTE);
      end else begin
        transfer(1'b1, active(), 1'b1, pick_word() + 2 * $urandom_range(1),
                 ahb_pkg::SIZE_HALF);
      end
    end
    foreach (used[i]) read_word(used[i]);
    end_test("3 byte and halfword lanes");

    for (int i = 0; i < N_XFER; i++) begin
      addr = pick_word();
      case (i % 4)
        0: transfer(1'b1, active(), 1'b1, addr + `MEM_WORDS * 4 * $urandom_range(1, 64),
                    ahb_pkg::SIZE_WORD);  // aliases onto addr if decoded wrongly
        1: transfer(1'b1, active(), 1'b1, addr, ahb_pkg::hsize_t'($urandom_range(3, 7)));
        2: transfer(1'b1, active(), 1'b1, addr + $urandom_range(1, 3), ahb_pkg::SIZE_WORD);
        default: transfer(1'b1, active(), 1'b1, addr + 2 * $urandom_range(1) + 1,
                          ahb_pkg::SIZE_HALF);
      endcase
      read_word(addr);
    end
    end_test("4 error responses");

    for (int i = 0; i < N_XFER; i++) begin
      addr = pick_word();
      case (i % 3)
        0: transfer(1'b1, ahb_pkg::IDLE, 1'b1, addr, ahb_pkg::SIZE_WORD);
        1: transfer(1'b1, ahb_pkg::BUSY, 1'b1, addr, ahb_pkg::SIZE_WORD);
        default: transfer(1'b0, active(), 1'b1, addr, ahb_pkg::SIZE_WORD);
      endcase
      read_word(addr);
    end
    end_test("5 idle, busy and deselected");

    for (int i = 0; i < N_XFER / 4; i++) begin
      addr = pick_word();
      drive_addr(1'b1, active(), 1'b1, addr, ahb_pkg::SIZE_WORD);
      stall = 1'b1;
      @(negedge HCLK);
      stall = 1'b0;
      drive_addr(1'b0, ahb_pkg::IDLE, 1'b0, '0, ahb_pkg::SIZE_WORD);
      hwdata = $urandom();
      @(negedge HCLK);
      read_word(addr);
    end
    end_test("6 stalled address phase");

    $display("checks: %0d, errors: %0d, timeouts: %0d", chk.checks, chk.errors, timeouts);
    if (chk.errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== ahb_mem_sub.f ====
+incdir+.
ahb_pkg.sv
mem_pkg.sv
access_if.sv
mem_if.sv
ahb_addr_phase.sv
word_storage.sv
ahb_data_phase.sv
ahb_mem_sub.sv
ahb_checker.sv
tb_ahb_mem_sub.sv

// ==== Makefile ====
# Verilator flow for the AHB memory subordinate

SIM := obj_dir/Vtb_ahb_mem_sub

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, look for the pass line in sim.log"
	@echo "make clean  remove obj_dir and sim.log"
	@echo "make help   show this list"

$(SIM): ahb_mem_sub.f $(wildcard *.sv) $(wildcard *.svh)
	verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
		-f ahb_mem_sub.f --top-module tb_ahb_mem_sub

test: $(SIM)
	./$(SIM) | tee sim.log
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
